//--- ccm/ccm_region.sv
/*
 * One closely coupled memory region
 *   - per-bank write strobes from clock enable and write enable
 *   - flip mask XORed into write data ahead of each bank
 *   - generate loop of single-port banks
 */
module ccm_region #(
    parameter int                 NUM_BANKS  = 4,
    parameter int                 INDEX_BITS = 6,
    parameter err_inj_pkg::lfsr_t LFSR_SEED  = err_inj_pkg::iccm_lfsr_seed
) (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  err_inj_pkg::region_mode_t              mode,
    input  logic [NUM_BANKS-1:0]                   clken,
    input  logic [NUM_BANKS-1:0]                   wren,
    input  logic [NUM_BANKS-1:0][INDEX_BITS-1:0]   addr,
    input  mem_cfg_pkg::ccm_word_t [NUM_BANKS-1:0] wr_data,
    output mem_cfg_pkg::ccm_word_t [NUM_BANKS-1:0] dout
);

    import mem_cfg_pkg::*;
    import err_inj_pkg::*;

    logic [NUM_BANKS-1:0]         wr_strobe;
    flip_mask_t [NUM_BANKS-1:0]   mask;
    ccm_word_t [NUM_BANKS-1:0]    bank_d;

    assign wr_strobe = clken & wren;

    //////////////////////////////////////////////////
    // Mask generation
    //////////////////////////////////////////////////

    err_inject #(
        .NUM_BANKS (NUM_BANKS),
        .LFSR_SEED (LFSR_SEED)
    ) err_inject_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .mode      (mode),
        .wr_strobe (wr_strobe),
        .mask      (mask)
    );

    //////////////////////////////////////////////////
    // Bank array
    //////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        // Corruption only ever enters storage here
        assign bank_d[i] = wr_data[i] ^ mask[i];

        sram_bank #(
            .INDEX_BITS (INDEX_BITS)
        ) sram_bank_i (
            .clk    (clk),
            .arst_n (arst_n),
            .en     (clken[i]),
            .we     (wren[i]),
            .addr   (addr[i]),
            .d      (bank_d[i]),
            .q      (dout[i])
        );
    end

endmodule

//--- ccm/err_inject.sv
/*
 * Flip-mask generator for the banks of one memory
 *   - 16-bit Galois LFSR, x^16+x^14+x^13+x^11+1
 *   - per-bank corrupt decision from the low LFSR bits
 *   - single or double bit mask at a position from the high byte
 */
module err_inject #(
    parameter int                 NUM_BANKS = 4,
    parameter err_inj_pkg::lfsr_t LFSR_SEED = err_inj_pkg::iccm_lfsr_seed
) (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  err_inj_pkg::region_mode_t              mode,
    input  logic [NUM_BANKS-1:0]                   wr_strobe,
    output err_inj_pkg::flip_mask_t [NUM_BANKS-1:0] mask
);

    import mem_cfg_pkg::*;
    import err_inj_pkg::*;

    localparam int    pos_bits  = $clog2(ccm_word_width);
    localparam lfsr_t lfsr_taps = 16'hB400;

    lfsr_t               lfsr;
    lfsr_t               lfsr_next;
    logic                inject_active;
    logic                lfsr_step;
    logic [pos_bits-1:0] flip_pos;
    logic [pos_bits-1:0] flip_pos_adj;
    flip_mask_t          single_mask;
    flip_mask_t          double_mask;

    assign inject_active = |mode;
    assign lfsr_step     = inject_active & (|wr_strobe);

    //////////////////////////////////////////////////
    // LFSR
    //////////////////////////////////////////////////

    // Right-shifting Galois form, feedback from bit 0
    assign lfsr_next = {1'b0, lfsr[lfsr_width-1:1]} ^ (lfsr[0] ? lfsr_taps : '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lfsr <= LFSR_SEED;
        end else if (lfsr_step) begin
            lfsr <= lfsr_next;
        end
    end

    //////////////////////////////////////////////////
    // Mask decode
    //////////////////////////////////////////////////

    // Position from the upper byte, folded into the word
    assign flip_pos = pos_bits'(lfsr[lfsr_width-1 -: 8] % ccm_word_width);

    // Neighbour bit wraps back to bit 0
    assign flip_pos_adj = (flip_pos == pos_bits'(ccm_word_width - 1))
                        ? '0 : flip_pos + 1'b1;

    assign single_mask = flip_mask_t'(1) << flip_pos;
    assign double_mask = single_mask | (flip_mask_t'(1) << flip_pos_adj);

    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            mask[i] = '0;
            // About half the writing banks get hit, one LFSR bit per bank
            if (inject_active && wr_strobe[i] && lfsr[i % lfsr_width]) begin
                mask[i] = mode[mode_double_bit] ? double_mask : single_mask;
            end
        end
    end

endmodule

//--- ccm/sram_bank.sv
/*
 * Behavioral single-port SRAM bank
 *   - synchronous write
 *   - registered read data, held between reads
 */
module sram_bank #(
    parameter int INDEX_BITS = 6
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   en,
    input  logic                   we,
    input  logic [INDEX_BITS-1:0]  addr,
    input  mem_cfg_pkg::ccm_word_t d,
    output mem_cfg_pkg::ccm_word_t q
);

    import mem_cfg_pkg::*;

    localparam int depth = 1 << INDEX_BITS;

    ccm_word_t mem [depth];

    // Storage array
    always_ff @(posedge clk) begin
        if (en && we) begin
            mem[addr] <= d;
        end
    end

    // Read port, q only moves on a read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (en && !we) begin
            q <= mem[addr];
        end
    end

endmodule

//--- common/err_inj_pkg.sv
/*
 * Write-data error injection definitions
 *   - mode word layout and per-memory mode field
 *   - flip mask and LFSR state types, LFSR seeds
 */
package err_inj_pkg;

    // Bit 0 ICCM single, bit 1 ICCM double, bit 2 DCCM single, bit 3 DCCM double
    typedef logic [3:0] err_inj_mode_t;

    localparam int region_mode_width = 2;
    localparam int mode_iccm_lsb     = 0;
    localparam int mode_dccm_lsb     = 2;

    // Per-memory field, double wins over single
    typedef logic [region_mode_width-1:0] region_mode_t;

    localparam int mode_single_bit = 0;
    localparam int mode_double_bit = 1;

    typedef logic [mem_cfg_pkg::ccm_word_width-1:0] flip_mask_t;

    localparam int lfsr_width = 16;

    typedef logic [lfsr_width-1:0] lfsr_t;

    localparam lfsr_t iccm_lfsr_seed = 16'hACE1;
    localparam lfsr_t dccm_lfsr_seed = 16'h5EED;

endpackage

//--- common/mem_cfg_pkg.sv
/*
 * Storage geometry of the closely coupled memories
 *   - stored word type with check bits
 *   - default bank counts and address widths for ICCM and DCCM
 */
package mem_cfg_pkg;

    //////////////////////////////////////////////////
    // Word format
    //////////////////////////////////////////////////

    // 32 data bits plus 7 check bits
    localparam int ccm_word_width = 39;

    typedef logic [ccm_word_width-1:0] ccm_word_t;

    //////////////////////////////////////////////////
    // Default geometry
    //////////////////////////////////////////////////

    localparam int iccm_banks_default = 4;
    localparam int dccm_banks_default = 4;

    // Address bits per bank
    localparam int iccm_index_bits_default = 6;
    localparam int dccm_index_bits_default = 7;

endpackage

//--- run.sh
#!/usr/bin/env bash
# Build and run the ICCM/DCCM SRAM model testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sram_export -Mdir obj_dir -f tb.f

out=$(./obj_dir/Vtb_sram_export)
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1

//--- src/sram_export.sv
/*
 * Banked ICCM and DCCM SRAM model
 *   - splits the injection mode word into one field per memory
 *   - one region instance per memory, each with its own geometry and seed
 */
module sram_export #(
    parameter int ICCM_NUM_BANKS  = mem_cfg_pkg::iccm_banks_default,
    parameter int DCCM_NUM_BANKS  = mem_cfg_pkg::dccm_banks_default,
    parameter int ICCM_INDEX_BITS = mem_cfg_pkg::iccm_index_bits_default,
    parameter int DCCM_INDEX_BITS = mem_cfg_pkg::dccm_index_bits_default
) (
    input  logic                                            el2_mem_export,
    input  logic                                            arst_n,
    input  err_inj_pkg::err_inj_mode_t                      error_injection_mode,

    // ICCM
    input  logic [ICCM_NUM_BANKS-1:0]                       iccm_clken,
    input  logic [ICCM_NUM_BANKS-1:0]                       iccm_wren_bank,
    input  logic [ICCM_NUM_BANKS-1:0][ICCM_INDEX_BITS-1:0]  iccm_addr_bank,
    input  mem_cfg_pkg::ccm_word_t [ICCM_NUM_BANKS-1:0]     iccm_wr_data_bank,
    output mem_cfg_pkg::ccm_word_t [ICCM_NUM_BANKS-1:0]     iccm_bank_dout,

    // DCCM
    input  logic [DCCM_NUM_BANKS-1:0]                       dccm_clken,
    input  logic [DCCM_NUM_BANKS-1:0]                       dccm_wren_bank,
    input  logic [DCCM_NUM_BANKS-1:0][DCCM_INDEX_BITS-1:0]  dccm_addr_bank,
    input  mem_cfg_pkg::ccm_word_t [DCCM_NUM_BANKS-1:0]     dccm_wr_data_bank,
    output mem_cfg_pkg::ccm_word_t [DCCM_NUM_BANKS-1:0]     dccm_bank_dout
);

    import err_inj_pkg::*;

    region_mode_t iccm_mode;
    region_mode_t dccm_mode;

    assign iccm_mode = error_injection_mode[mode_iccm_lsb +: region_mode_width];
    assign dccm_mode = error_injection_mode[mode_dccm_lsb +: region_mode_width];

    //////////////////////////////////////////////////
    // ICCM
    //////////////////////////////////////////////////

    ccm_region #(
        .NUM_BANKS  (ICCM_NUM_BANKS),
        .INDEX_BITS (ICCM_INDEX_BITS),
        .LFSR_SEED  (iccm_lfsr_seed)
    ) iccm_region (
        .clk     (el2_mem_export),
        .arst_n  (arst_n),
        .mode    (iccm_mode),
        .clken   (iccm_clken),
        .wren    (iccm_wren_bank),
        .addr    (iccm_addr_bank),
        .wr_data (iccm_wr_data_bank),
        .dout    (iccm_bank_dout)
    );

    //////////////////////////////////////////////////
    // DCCM
    //////////////////////////////////////////////////

    ccm_region #(
        .NUM_BANKS  (DCCM_NUM_BANKS),
        .INDEX_BITS (DCCM_INDEX_BITS),
        .LFSR_SEED  (dccm_lfsr_seed)
    ) dccm_region (
        .clk     (el2_mem_export),
        .arst_n  (arst_n),
        .mode    (dccm_mode),
        .clken   (dccm_clken),
        .wren    (dccm_wren_bank),
        .addr    (dccm_addr_bank),
        .wr_data (dccm_wr_data_bank),
        .dout    (dccm_bank_dout)
    );

endmodule

//--- tb.f
common/mem_cfg_pkg.sv
common/err_inj_pkg.sv
ccm/sram_bank.sv
ccm/err_inject.sv
ccm/ccm_region.sv
src/sram_export.sv
verification/sram_export_sva.sv
verification/tb_sram_export.sv

//--- verification/sram_export_sva.sv
/*
 * Bound checks for one memory region
 *   - flip mask weight against region mode and write strobe
 *   - read data held in cycles without a read
 *   - read data cleared by reset
 */
module sram_export_sva #(
    parameter int NUM_BANKS = 4
) (
    input logic                                    clk,
    input logic                                    arst_n,
    input err_inj_pkg::region_mode_t               mode,
    input logic [NUM_BANKS-1:0]                    clken,
    input logic [NUM_BANKS-1:0]                    wren,
    input err_inj_pkg::flip_mask_t [NUM_BANKS-1:0] mask,
    input mem_cfg_pkg::ccm_word_t [NUM_BANKS-1:0]  dout
);

    timeunit 1ns;
    timeprecision 1ps;

    import err_inj_pkg::*;

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        // No mode or no write on this bank means a clean mask
        a_mask_idle: assert property (@(posedge clk) disable iff (!arst_n)
            (mode == '0 || !(clken[i] && wren[i])) |-> (mask[i] == '0))
            else $error("bank %0d has a flip mask without an injected write", i);

        a_mask_single: assert property (@(posedge clk) disable iff (!arst_n)
            (mode[mode_single_bit] && !mode[mode_double_bit]) |-> ($countones(mask[i]) <= 1))
            else $error("bank %0d mask weight above one in single mode", i);

        // Double wins whenever its bit is set
        a_mask_double: assert property (@(posedge clk) disable iff (!arst_n)
            mode[mode_double_bit] |->
                ($countones(mask[i]) == 0 || $countones(mask[i]) == 2))
            else $error("bank %0d mask weight not 0 or 2 in double mode", i);

        a_dout_hold: assert property (@(posedge clk) disable iff (!arst_n)
            !(clken[i] && !wren[i]) |=> $stable(dout[i]))
            else $error("bank %0d dout moved without a read", i);

        a_dout_reset: assert property (@(posedge clk)
            $rose(arst_n) |-> (dout[i] == '0))
            else $error("bank %0d dout not zero after reset", i);
    end

endmodule

bind ccm_region sram_export_sva #(
    .NUM_BANKS (NUM_BANKS)
) sram_export_sva_i (
    .clk    (clk),
    .arst_n (arst_n),
    .mode   (mode),
    .clken  (clken),
    .wren   (wren),
    .mask   (mask),
    .dout   (dout)
);

//--- verification/tb_sram_export.sv
/*
 * Directed testbench for the banked ICCM and DCCM model
 *   - clock, reset and per-cycle access helpers
 *   - compare tasks for exact words and injected bit flips
 *   - reset, clean, injection, recovery and read-hold tests
 */
module tb_sram_export;

    timeunit 1ns;
    timeprecision 1ps;

    import mem_cfg_pkg::*;
    import err_inj_pkg::*;

    localparam int nb_i       = iccm_banks_default;
    localparam int nb_d       = dccm_banks_default;
    localparam int ib_i       = iccm_index_bits_default;
    localparam int ib_d       = dccm_index_bits_default;
    localparam int max_batch  = 64;
    localparam int edge_slack = 4;

    logic                        el2_mem_export;
    logic                        arst_n;
    err_inj_mode_t               error_injection_mode;
    logic [nb_i-1:0]             iccm_clken;
    logic [nb_i-1:0]             iccm_wren_bank;
    logic [nb_i-1:0][ib_i-1:0]   iccm_addr_bank;
    ccm_word_t [nb_i-1:0]        iccm_wr_data_bank;
    ccm_word_t [nb_i-1:0]        iccm_bank_dout;
    logic [nb_d-1:0]             dccm_clken;
    logic [nb_d-1:0]             dccm_wren_bank;
    logic [nb_d-1:0][ib_d-1:0]   dccm_addr_bank;
    ccm_word_t [nb_d-1:0]        dccm_wr_data_bank;
    ccm_word_t [nb_d-1:0]        dccm_bank_dout;

    integer    seed;
    int        cycle_count;
    int        errors;
    int        tests_run;
    int        tests_failed;
    int        flips_i;
    int        flips_d;
    ccm_word_t exp_i [max_batch][nb_i];
    ccm_word_t exp_d [max_batch][nb_d];

    sram_export sram_export_i (
        .el2_mem_export       (el2_mem_export),
        .arst_n               (arst_n),
        .error_injection_mode (error_injection_mode),
        .iccm_clken           (iccm_clken),
        .iccm_wren_bank       (iccm_wren_bank),
        .iccm_addr_bank       (iccm_addr_bank),
        .iccm_wr_data_bank    (iccm_wr_data_bank),
        .iccm_bank_dout       (iccm_bank_dout),
        .dccm_clken           (dccm_clken),
        .dccm_wren_bank       (dccm_wren_bank),
        .dccm_addr_bank       (dccm_addr_bank),
        .dccm_wr_data_bank    (dccm_wr_data_bank),
        .dccm_bank_dout       (dccm_bank_dout)
    );

    always #5 el2_mem_export = ~el2_mem_export;

    always @(posedge el2_mem_export) begin
        cycle_count <= cycle_count + 1;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Returns on a falling edge, n rising edges later
    task automatic wait_cycles(input int n);
        int start;
        int spins;
        start = cycle_count;
        spins = 0;
        while ((cycle_count - start) < n && spins < n + edge_slack) begin
            @(negedge el2_mem_export);
            spins++;
        end
        if ((cycle_count - start) < n) begin
            $display("Timeout: only %0d of %0d clock cycles seen after %0d falling edges",
                     cycle_count - start, n, spins);
            $display("tests failed");
            $finish;
        end
    endtask

    task automatic idle_inputs();
        iccm_clken     = '0;
        iccm_wren_bank = '0;
        dccm_clken     = '0;
        dccm_wren_bank = '0;
    endtask

    function automatic ccm_word_t random_word();
        logic [63:0] raw;
        raw = {$random(seed), $random(seed)};
        return raw[ccm_word_width-1:0];
    endfunction

    // Stride 7 is odd, so entries of one bank never share an address
    function automatic logic [ib_i-1:0] iccm_addr_of(input int k, input int b);
        return ib_i'((k * 7 + b) % (1 << ib_i));
    endfunction

    function automatic logic [ib_d-1:0] dccm_addr_of(input int k, input int b);
        return ib_d'((k * 7 + b) % (1 << ib_d));
    endfunction

    task automatic check_word(input ccm_word_t expected, input ccm_word_t actual,
                              input string what);
        if (actual !== expected) begin
            errors++;
            $display("FAIL @ %0t: %s read %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_flips(input ccm_word_t written, input ccm_word_t read_back,
                               input region_mode_t mode, input string what,
                               output bit flipped);
        int diff;
        bit ok;
        diff = $countones(written ^ read_back);
        if (mode == '0) begin
            ok = (diff == 0);
        end else if (mode[mode_double_bit]) begin
            ok = (diff == 0 || diff == 2);
        end else begin
            ok = (diff <= 1);
        end
        flipped = (diff != 0);
        if (!ok || $isunknown(read_back)) begin
            errors++;
            $display("FAIL @ %0t: %s differs in %0d bits (mode %b), read %h, wrote %h",
                     $time, what, diff, mode, read_back, written);
        end
    endtask

    task automatic write_batch(input int count);
        for (int k = 0; k < count; k++) begin
            for (int b = 0; b < nb_i; b++) begin
                exp_i[k][b]          = random_word();
                iccm_addr_bank[b]    = iccm_addr_of(k, b);
                iccm_wr_data_bank[b] = exp_i[k][b];
            end
            for (int b = 0; b < nb_d; b++) begin
                exp_d[k][b]          = random_word();
                dccm_addr_bank[b]    = dccm_addr_of(k, b);
                dccm_wr_data_bank[b] = exp_d[k][b];
            end
            iccm_clken     = '1;
            iccm_wren_bank = '1;
            dccm_clken     = '1;
            dccm_wren_bank = '1;
            wait_cycles(1);
        end
        idle_inputs();
    endtask

    // Clean regions compare exactly, injected ones by flip count
    task automatic read_batch(input int count, input err_inj_mode_t m);
        region_mode_t mode_i;
        region_mode_t mode_d;
        bit           flipped;
        mode_i = m[mode_iccm_lsb +: region_mode_width];
        mode_d = m[mode_dccm_lsb +: region_mode_width];
        for (int k = 0; k < count; k++) begin
            for (int b = 0; b < nb_i; b++) begin
                iccm_addr_bank[b] = iccm_addr_of(k, b);
            end
            for (int b = 0; b < nb_d; b++) begin
                dccm_addr_bank[b] = dccm_addr_of(k, b);
            end
            iccm_clken     = '1;
            iccm_wren_bank = '0;
            dccm_clken     = '1;
            dccm_wren_bank = '0;
            wait_cycles(1);
            for (int b = 0; b < nb_i; b++) begin
                if (mode_i == '0) begin
                    check_word(exp_i[k][b], iccm_bank_dout[b],
                               $sformatf("ICCM bank %0d entry %0d", b, k));
                end else begin
                    check_flips(exp_i[k][b], iccm_bank_dout[b], mode_i,
                                $sformatf("ICCM bank %0d entry %0d", b, k), flipped);
                    flips_i += int'(flipped);
                end
            end
            for (int b = 0; b < nb_d; b++) begin
                if (mode_d == '0) begin
                    check_word(exp_d[k][b], dccm_bank_dout[b],
                               $sformatf("DCCM bank %0d entry %0d", b, k));
                end else begin
                    check_flips(exp_d[k][b], dccm_bank_dout[b], mode_d,
                                $sformatf("DCCM bank %0d entry %0d", b, k), flipped);
                    flips_d += int'(flipped);
                end
            end
        end
        idle_inputs();
    endtask

    task automatic injected_batch(input err_inj_mode_t m, input int count);
        error_injection_mode = m;
        flips_i = 0;
        flips_d = 0;
        write_batch(count);
        read_batch(count, m);
    endtask

    task automatic expect_some_flips(input int flips, input string what);
        if (flips == 0) begin
            errors++;
            $display("FAIL @ %0t: %s injection corrupted none of the writes", $time, what);
        end
    endtask

    task automatic close_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("[%0t] %s: ok", $time, name);
        end else begin
            tests_failed++;
            $display("[%0t] %s: %0d mismatches", $time, name, errors - errors_before);
        end
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_reset_values();
        int e0;
        e0 = errors;
        for (int b = 0; b < nb_i; b++) begin
            check_word('0, iccm_bank_dout[b], $sformatf("ICCM bank %0d after reset", b));
        end
        for (int b = 0; b < nb_d; b++) begin
            check_word('0, dccm_bank_dout[b], $sformatf("DCCM bank %0d after reset", b));
        end
        close_test("reset values", e0);
    endtask

    task automatic test_clean_rw();
        int e0;
        e0 = errors;
        injected_batch(4'b0000, 16);
        close_test("clean write and read", e0);
    endtask

    task automatic test_iccm_single();
        int e0;
        e0 = errors;
        injected_batch(4'b0001, 64);
        expect_some_flips(flips_i, "ICCM single");
        close_test("ICCM single injection", e0);
    endtask

    task automatic test_dccm_double();
        int e0;
        e0 = errors;
        injected_batch(4'b1000, 64);
        expect_some_flips(flips_d, "DCCM double");
        // Both DCCM bits set, double must win
        injected_batch(4'b1100, 32);
        expect_some_flips(flips_d, "DCCM single plus double");
        close_test("DCCM double injection", e0);
    endtask

    task automatic test_recovery();
        int e0;
        e0 = errors;
        injected_batch(4'b0000, 64);
        close_test("recovery after injection", e0);
    endtask

    task automatic test_read_hold();
        int        e0;
        ccm_word_t held_i [nb_i];
        ccm_word_t held_d [nb_d];
        e0 = errors;
        error_injection_mode = '0;
        for (int b = 0; b < nb_i; b++) begin
            iccm_addr_bank[b] = iccm_addr_of(3, b);
        end
        for (int b = 0; b < nb_d; b++) begin
            dccm_addr_bank[b] = dccm_addr_of(3, b);
        end
        iccm_clken = '1;
        dccm_clken = '1;
        wait_cycles(1);
        idle_inputs();
        for (int b = 0; b < nb_i; b++) begin
            held_i[b] = iccm_bank_dout[b];
            check_word(exp_i[3][b], held_i[b], $sformatf("ICCM bank %0d hold read", b));
        end
        for (int b = 0; b < nb_d; b++) begin
            held_d[b] = dccm_bank_dout[b];
            check_word(exp_d[3][b], held_d[b], $sformatf("DCCM bank %0d hold read", b));
        end
        wait_cycles(3);
        // Writes to a neighbouring entry of the same banks
        for (int b = 0; b < nb_i; b++) begin
            exp_i[4][b]          = random_word();
            iccm_addr_bank[b]    = iccm_addr_of(4, b);
            iccm_wr_data_bank[b] = exp_i[4][b];
        end
        for (int b = 0; b < nb_d; b++) begin
            exp_d[4][b]          = random_word();
            dccm_addr_bank[b]    = dccm_addr_of(4, b);
            dccm_wr_data_bank[b] = exp_d[4][b];
        end
        iccm_clken     = '1;
        iccm_wren_bank = '1;
        dccm_clken     = '1;
        dccm_wren_bank = '1;
        wait_cycles(2);
        idle_inputs();
        wait_cycles(1);
        for (int b = 0; b < nb_i; b++) begin
            check_word(held_i[b], iccm_bank_dout[b], $sformatf("ICCM bank %0d held dout", b));
        end
        for (int b = 0; b < nb_d; b++) begin
            check_word(held_d[b], dccm_bank_dout[b], $sformatf("DCCM bank %0d held dout", b));
        end
        close_test("read data hold", e0);
    endtask

    initial begin
        seed                 = 32'ha972;
        cycle_count          = 0;
        errors               = 0;
        tests_run            = 0;
        tests_failed         = 0;
        flips_i              = 0;
        flips_d              = 0;
        el2_mem_export       = 1'b0;
        arst_n               = 1'b0;
        error_injection_mode = '0;
        iccm_addr_bank       = '0;
        iccm_wr_data_bank    = '0;
        dccm_addr_bank       = '0;
        dccm_wr_data_bank    = '0;
        idle_inputs();

        wait_cycles(4);
        arst_n = 1'b1;
        wait_cycles(1);

        test_reset_values();
        test_clean_rw();
        test_iccm_single();
        test_dccm_double();
        test_recovery();
        test_read_hold();

        $display("%0d tests run, %0d failing, %0d mismatches", tests_run, tests_failed, errors);
        if (tests_failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
